// ==== verilog/pipe_consts.svh ====
`ifndef PIPE_CONSTS_SVH
`define PIPE_CONSTS_SVH

// data word width, also used for the pc
`define DATA_W 32

// register file index width, 32 registers
`define REG_ADDR_W 5

// data memory word address width, 256 words
`define DMEM_ADDR_W 8

`endif

// ==== verilog/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

    // alu operation code, mips funct style values
    typedef logic [5:0] alu_op_t;

    localparam alu_op_t ALU_SLL  = 6'h00;
    localparam alu_op_t ALU_SRL  = 6'h02;
    localparam alu_op_t ALU_SRA  = 6'h03;
    localparam alu_op_t ALU_LUI  = 6'h0f;
    localparam alu_op_t ALU_ADD  = 6'h20;
    localparam alu_op_t ALU_SUB  = 6'h22;
    localparam alu_op_t ALU_AND  = 6'h24;
    localparam alu_op_t ALU_OR   = 6'h25;
    localparam alu_op_t ALU_XOR  = 6'h26;
    localparam alu_op_t ALU_NOR  = 6'h27;
    localparam alu_op_t ALU_SLT  = 6'h2a;
    localparam alu_op_t ALU_SLTU = 6'h2b;

    // writeback source, code 3 falls back to the alu result
    typedef logic [1:0] wb_sel_t;

    localparam wb_sel_t WB_ALU  = 2'd0;
    localparam wb_sel_t WB_MEM  = 2'd1;
    localparam wb_sel_t WB_LINK = 2'd2;

endpackage

`default_nettype wire

// ==== verilog/datapath_pkg.sv ====
`default_nettype none

`include "pipe_consts.svh"

package datapath_pkg;

    // operands, results and pc values
    typedef logic [`DATA_W-1:0] word_t;

    // architectural register number
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // word index into the data memory
    typedef logic [`DMEM_ADDR_W-1:0] dmem_addr_t;

endpackage

`default_nettype wire

// ==== verilog/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu
    import datapath_pkg::*, isa_pkg::*;
(
    input  word_t   a,
    input  word_t   b,
    input  alu_op_t op,
    output word_t   result
);

    // shift amount comes from operand a
    logic [4:0] shamt;

    assign shamt = a[4:0];

    always_comb begin
        case (op)
            ALU_ADD: begin
                result = a + b;
            end
            ALU_SUB: begin
                result = a - b;
            end
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_XOR: result = a ^ b;
            ALU_NOR: result = ~(a | b);
            // compares give 0 or 1 in bit 0
            ALU_SLT: begin
                result = word_t'($signed(a) < $signed(b));
            end
            ALU_SLTU: begin
                result = word_t'(a < b);
            end
            // shifts act on operand b
            ALU_SLL: result = b << shamt;
            ALU_SRL: result = b >> shamt;
            ALU_SRA: begin
                // keep the sign bit on the way down
                result = word_t'($signed(b) >>> shamt);
            end
            ALU_LUI: result = b << 16;
            default: begin
                // unknown codes give zero
                result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_stage
    import datapath_pkg::*, isa_pkg::*;
(
    input  reg_addr_t rs,
    input  reg_addr_t rt,
    input  word_t     rs_data,
    input  word_t     rt_data,
    input  word_t     imm,
    input  logic      alu_src,
    input  alu_op_t   alu_op,
    input  reg_addr_t fwd_mem_reg,
    input  logic      fwd_mem_en,
    input  word_t     fwd_mem_data,
    input  reg_addr_t fwd_wb_reg,
    input  logic      fwd_wb_en,
    input  word_t     fwd_wb_data,
    output word_t     alu_result,
    output word_t     store_data
);

    word_t op_a;
    word_t op_b;
    word_t rs_fwd;
    word_t rt_fwd;

    // only real writers to a nonzero register forward
    logic mem_hit_rs;
    logic mem_hit_rt;
    logic wb_hit_rs;
    logic wb_hit_rt;

    assign mem_hit_rs = fwd_mem_en && (fwd_mem_reg != '0) && (fwd_mem_reg == rs);
    assign mem_hit_rt = fwd_mem_en && (fwd_mem_reg != '0) && (fwd_mem_reg == rt);
    assign wb_hit_rs  = fwd_wb_en && (fwd_wb_reg != '0) && (fwd_wb_reg == rs);
    assign wb_hit_rt  = fwd_wb_en && (fwd_wb_reg != '0) && (fwd_wb_reg == rt);

    // younger producer in ex/mem wins over writeback
    assign rs_fwd = mem_hit_rs ? fwd_mem_data : (wb_hit_rs ? fwd_wb_data : rs_data);
    assign rt_fwd = mem_hit_rt ? fwd_mem_data : (wb_hit_rt ? fwd_wb_data : rt_data);

    assign op_a = rs_fwd;
    // immediate replaces rt for i-type ops
    assign op_b = alu_src ? imm : rt_fwd;

    // stores always take the forwarded rt value
    assign store_data = rt_fwd;

    alu u_alu (
        .a      (op_a),
        .b      (op_b),
        .op     (alu_op),
        .result (alu_result)
    );

endmodule

`default_nettype wire

// ==== verilog/ex_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_mem
    import datapath_pkg::*, isa_pkg::*;
(
    input  logic      clk,
    input  logic      reset,

    // execute results
    input  word_t     alu_result,
    input  word_t     read_data2,
    input  reg_addr_t regdst,
    input  word_t     pc_in,

    // control from decode
    input  logic      regwrite,
    input  logic      memwrite,
    input  logic      memread,
    input  wb_sel_t   memtoreg,
    input  alu_op_t   alu_op,

    // memory stage view
    output word_t     alu_result_out,
    output word_t     read_data2_out,
    output reg_addr_t regdst_out,
    output word_t     pc_out,
    output logic      regwrite_out,
    output logic      memwrite_out,
    output logic      memread_out,
    output wb_sel_t   memtoreg_out,
    output alu_op_t   alu_op_out
);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            // all zero is a bubble
            alu_result_out <= '0;
            read_data2_out <= '0;
            regdst_out     <= '0;
            pc_out         <= '0;
            regwrite_out   <= 1'b0;
            memwrite_out   <= 1'b0;
            memread_out    <= 1'b0;
            memtoreg_out   <= WB_ALU;
            alu_op_out     <= '0;
        end else begin
            alu_result_out <= alu_result;
            read_data2_out <= read_data2;
            regdst_out     <= regdst;
            pc_out         <= pc_in;
            // control passes straight through
            regwrite_out   <= regwrite;
            memwrite_out   <= memwrite;
            memread_out    <= memread;
            memtoreg_out   <= memtoreg;
            // kept for a future access size decode
            alu_op_out     <= alu_op;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/data_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pipe_consts.svh"

module data_memory
    import datapath_pkg::*;
(
    input  logic       clk,
    input  dmem_addr_t addr,
    input  logic       write_en,
    input  word_t      write_data,
    input  logic       read_en,
    output word_t      read_data
);

    localparam int DEPTH = 1 << `DMEM_ADDR_W;

    // word array, contents survive reset
    word_t mem [DEPTH];

    // store lands on the clock edge
    always_ff @(posedge clk) begin
        if (write_en) begin
            mem[addr] <= write_data;
        end
    end

    // zero unless a load, so other ops see no memory data
    assign read_data = read_en ? mem[addr] : '0;

endmodule

`default_nettype wire

// ==== verilog/writeback_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module writeback_stage
    import datapath_pkg::*, isa_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  word_t     alu_result,
    input  word_t     mem_data,
    input  word_t     pc_in,
    input  reg_addr_t regdst,
    input  logic      regwrite,
    input  wb_sel_t   memtoreg,
    output logic      wb_en,
    output reg_addr_t wb_reg,
    output word_t     wb_data
);

    // mem/wb register contents
    word_t     alu_q;
    word_t     mem_q;
    word_t     pc_q;
    reg_addr_t regdst_q;
    logic      regwrite_q;
    wb_sel_t   memtoreg_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            alu_q      <= '0;
            mem_q      <= '0;
            pc_q       <= '0;
            regdst_q   <= '0;
            regwrite_q <= 1'b0;
            memtoreg_q <= WB_ALU;
        end else begin
            alu_q      <= alu_result;
            mem_q      <= mem_data;
            pc_q       <= pc_in;
            regdst_q   <= regdst;
            regwrite_q <= regwrite;
            memtoreg_q <= memtoreg;
        end
    end

    assign wb_en  = regwrite_q;
    assign wb_reg = regdst_q;

    // pick the value for the register file
    always_comb begin
        case (memtoreg_q)
            WB_MEM:  wb_data = mem_q;
            // link writes the incremented pc
            WB_LINK: wb_data = pc_q;
            default: wb_data = alu_q;
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/pipeline_backend.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pipe_consts.svh"

module pipeline_backend
    import datapath_pkg::*, isa_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  reg_addr_t rs,
    input  reg_addr_t rt,
    input  word_t     rs_data,
    input  word_t     rt_data,
    input  word_t     imm,
    input  logic      alu_src,
    input  alu_op_t   alu_op,
    input  reg_addr_t regdst,
    input  word_t     pc_in,
    input  logic      regwrite,
    input  logic      memwrite,
    input  logic      memread,
    input  wb_sel_t   memtoreg,
    output logic      wb_en,
    output reg_addr_t wb_reg,
    output word_t     wb_data
);

    // execute outputs
    word_t      ex_result;
    word_t      ex_store;

    // ex/mem register outputs
    word_t      mem_result;
    word_t      mem_store;
    reg_addr_t  mem_regdst;
    word_t      mem_pc;
    logic       mem_regwrite;
    logic       mem_memwrite;
    logic       mem_memread;
    wb_sel_t    mem_memtoreg;

    // memory side
    dmem_addr_t dmem_addr;
    word_t      dmem_rdata;

    // byte address to word index
    assign dmem_addr = mem_result[`DMEM_ADDR_W+1:2];

    execute_stage u_execute (
        .rs           (rs),
        .rt           (rt),
        .rs_data      (rs_data),
        .rt_data      (rt_data),
        .imm          (imm),
        .alu_src      (alu_src),
        .alu_op       (alu_op),
        // distance one producer
        .fwd_mem_reg  (mem_regdst),
        .fwd_mem_en   (mem_regwrite),
        .fwd_mem_data (mem_result),
        // distance two producer
        .fwd_wb_reg   (wb_reg),
        .fwd_wb_en    (wb_en),
        .fwd_wb_data  (wb_data),
        .alu_result   (ex_result),
        .store_data   (ex_store)
    );

    ex_mem u_ex_mem (
        .clk            (clk),
        .reset          (reset),
        .alu_result     (ex_result),
        .read_data2     (ex_store),
        .regdst         (regdst),
        .pc_in          (pc_in),
        .regwrite       (regwrite),
        .memwrite       (memwrite),
        .memread        (memread),
        .memtoreg       (memtoreg),
        .alu_op         (alu_op),
        .alu_result_out (mem_result),
        .read_data2_out (mem_store),
        .regdst_out     (mem_regdst),
        .pc_out         (mem_pc),
        .regwrite_out   (mem_regwrite),
        .memwrite_out   (mem_memwrite),
        .memread_out    (mem_memread),
        .memtoreg_out   (mem_memtoreg),
        // no consumer downstream yet
        .alu_op_out     ()
    );

    data_memory u_dmem (
        .clk        (clk),
        .addr       (dmem_addr),
        .write_en   (mem_memwrite),
        .write_data (mem_store),
        .read_en    (mem_memread),
        .read_data  (dmem_rdata)
    );

    writeback_stage u_writeback (
        .clk        (clk),
        .reset      (reset),
        .alu_result (mem_result),
        .mem_data   (dmem_rdata),
        .pc_in      (mem_pc),
        .regdst     (mem_regdst),
        .regwrite   (mem_regwrite),
        .memtoreg   (mem_memtoreg),
        .wb_en      (wb_en),
        .wb_reg     (wb_reg),
        .wb_data    (wb_data)
    );

endmodule

`default_nettype wire

// ==== verif/tb_pipeline_backend.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pipe_consts.svh"

module tb_pipeline_backend
    import datapath_pkg::*, isa_pkg::*;
();

    logic      clk;
    logic      reset;
    reg_addr_t rs;
    reg_addr_t rt;
    word_t     rs_data;
    word_t     rt_data;
    word_t     imm;
    logic      alu_src;
    alu_op_t   alu_op;
    reg_addr_t regdst;
    word_t     pc_in;
    logic      regwrite;
    logic      memwrite;
    logic      memread;
    wb_sel_t   memtoreg;
    logic      wb_en;
    reg_addr_t wb_reg;
    word_t     wb_data;

    // architectural file fed only by observed writebacks
    word_t arch_regs [32];
    // program order model updated at issue
    word_t ref_regs [32];
    word_t ref_mem [1 << `DMEM_ADDR_W];

    // expected writebacks in issue order
    int        q_tag [$];
    logic      q_en [$];
    reg_addr_t q_reg [$];
    word_t     q_data [$];
    string     q_name [$];

    int    cycle;
    int    errors;
    word_t pc;

    pipeline_backend dut (
        .clk      (clk),
        .reset    (reset),
        .rs       (rs),
        .rt       (rt),
        .rs_data  (rs_data),
        .rt_data  (rt_data),
        .imm      (imm),
        .alu_src  (alu_src),
        .alu_op   (alu_op),
        .regdst   (regdst),
        .pc_in    (pc_in),
        .regwrite (regwrite),
        .memwrite (memwrite),
        .memread  (memread),
        .memtoreg (memtoreg),
        .wb_en    (wb_en),
        .wb_reg   (wb_reg),
        .wb_data  (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    function automatic word_t rnd();
        return $urandom;
    endfunction

    // expected alu result straight from the encoding rules
    function automatic word_t ref_alu(alu_op_t op, word_t a, word_t b);
        word_t r;
        case (op)
            ALU_ADD:  r = a + b;
            ALU_SUB:  r = a - b;
            ALU_AND:  r = a & b;
            ALU_OR:   r = a | b;
            ALU_XOR:  r = a ^ b;
            ALU_NOR:  r = ~(a | b);
            ALU_SLT:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLTU: r = (a < b) ? 32'd1 : 32'd0;
            ALU_SLL:  r = b << a[4:0];
            ALU_SRL:  r = b >> a[4:0];
            ALU_SRA:  r = $signed(b) >>> a[4:0];
            ALU_LUI:  r = {b[15:0], 16'h0000};
            default:  r = 32'h0;
        endcase
        return r;
    endfunction

    task automatic check_value(string name, word_t expected, word_t actual);
        if (expected !== actual) begin
            errors++;
            $display("[FAIL] %s expected %08h actual %08h", name, expected, actual);
        end
    endtask

    // result is visible two edges after issue
    always @(negedge clk) begin
        if (!reset) begin
            // nothing due means no writeback either
            if (q_tag.size() == 0 || q_tag[0] + 2 > cycle) begin
                check_value("idle wb_en", 32'h0, word_t'(wb_en));
            end
            while (q_tag.size() > 0 && q_tag[0] + 2 <= cycle) begin
                check_value({q_name[0], " wb_en"}, word_t'(q_en[0]), word_t'(wb_en));
                if (q_en[0]) begin
                    check_value({q_name[0], " wb_reg"}, word_t'(q_reg[0]), word_t'(wb_reg));
                    check_value({q_name[0], " wb_data"}, q_data[0], wb_data);
                end
                void'(q_tag.pop_front());
                void'(q_en.pop_front());
                void'(q_reg.pop_front());
                void'(q_data.pop_front());
                void'(q_name.pop_front());
            end
        end
    end

    // register file write lands on the edge that ends writeback
    always @(posedge clk) begin
        if (wb_en && wb_reg != '0) begin
            arch_regs[wb_reg] = wb_data;
        end
    end

    task automatic issue(string name, reg_addr_t s, reg_addr_t t, word_t im, logic src,
                         alu_op_t op, reg_addr_t rd, logic rw, logic mw, logic mr,
                         wb_sel_t sel);
        word_t      a;
        word_t      b;
        word_t      res;
        word_t      mval;
        word_t      val;
        dmem_addr_t addr;
        @(negedge clk);
        pc = pc + 32'd4;
        a = ref_regs[s];
        b = src ? im : ref_regs[t];
        res = ref_alu(op, a, b);
        addr = res[`DMEM_ADDR_W+1:2];
        mval = mr ? ref_mem[addr] : 32'h0;
        if (sel == WB_MEM) begin
            val = mval;
        end else if (sel == WB_LINK) begin
            val = pc;
        end else begin
            val = res;
        end
        if (mw) begin
            ref_mem[addr] = ref_regs[t];
        end
        if (rw && rd != '0) begin
            ref_regs[rd] = val;
        end
        q_tag.push_back(cycle);
        q_en.push_back(rw);
        q_reg.push_back(rd);
        q_data.push_back(val);
        q_name.push_back(name);
        // stale values that the dut must forward over
        rs = s;
        rt = t;
        rs_data = arch_regs[s];
        rt_data = arch_regs[t];
        imm = im;
        alu_src = src;
        alu_op = op;
        regdst = rd;
        pc_in = pc;
        regwrite = rw;
        memwrite = mw;
        memread = mr;
        memtoreg = sel;
    endtask

    task automatic bubble(string name);
        issue(name, 5'd0, 5'd0, 32'h0, 1'b0, ALU_SLL, 5'd0, 1'b0, 1'b0, 1'b0, WB_ALU);
    endtask

    // one random instruction on registers 0..top
    task automatic random_instr(string name, int top);
        word_t     r;
        reg_addr_t s;
        reg_addr_t t;
        reg_addr_t d;
        alu_op_t   op;
        r = rnd();
        s = reg_addr_t'(r[7:0] % (top + 1));
        t = reg_addr_t'(r[15:8] % (top + 1));
        d = reg_addr_t'(r[23:16] % (top + 1));
        op = r[29:24];
        if (r[30]) begin
            op = ALU_ADD + alu_op_t'(r[27:26] * 2);
        end
        case (rnd() % 8)
            0, 1, 2, 3: begin
                issue(name, s, t, rnd(), r[31], op, d, 1'b1, 1'b0, 1'b0, r[31] ? WB_ALU : 2'd3);
            end
            4: begin
                // load with an empty slot after it to avoid load use
                issue(name, 5'd0, t, {22'h0, r[7:0], 2'b00}, 1'b1, ALU_ADD, d,
                      1'b1, 1'b0, 1'b1, WB_MEM);
                bubble(name);
            end
            5: begin
                issue(name, 5'd0, t, {22'h0, r[7:0], 2'b00}, 1'b1, ALU_ADD, d,
                      1'b0, 1'b1, 1'b0, WB_ALU);
            end
            6: begin
                // link value is not forwarded from ex/mem
                issue(name, s, t, rnd(), 1'b1, op, d, 1'b1, 1'b0, 1'b0, WB_LINK);
                bubble(name);
            end
            default: begin
                issue(name, s, t, rnd(), 1'b0, op, d, 1'b0, 1'b0, r[0], r[2:1]);
            end
        endcase
    endtask

    initial begin
        alu_op_t ops [13];
        int      guard;
        void'($urandom(32'h726e768d));
        errors = 0;
        cycle = 0;
        pc = 32'h0000_1000;
        rs = '0;
        rt = '0;
        rs_data = '0;
        rt_data = '0;
        imm = '0;
        alu_src = 1'b0;
        alu_op = '0;
        regdst = '0;
        pc_in = '0;
        regwrite = 1'b0;
        memwrite = 1'b0;
        memread = 1'b0;
        memtoreg = WB_ALU;
        for (int i = 0; i < 32; i++) begin
            arch_regs[i] = (i == 0) ? 32'h0 : rnd();
            ref_regs[i] = arch_regs[i];
        end
        reset = 1'b1;
        repeat (5) @(posedge clk);
        check_value("reset wb_en", 32'h0, word_t'(wb_en));
        @(negedge clk);
        reset = 1'b0;

        // bubbles after reset
        repeat (6) bubble("bubbles");

        // every op with register and immediate sources
        ops = '{ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR, ALU_SLT,
                ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI, 6'h3f};
        for (int k = 0; k < 4; k++) begin
            // fresh random operands for each round
            issue("alu_ops", 5'd0, 5'd0, rnd(), 1'b1, ALU_OR, 5'd10,
                  1'b1, 1'b0, 1'b0, WB_ALU);
            issue("alu_ops", 5'd0, 5'd0, rnd(), 1'b1, ALU_OR, 5'd11,
                  1'b1, 1'b0, 1'b0, WB_ALU);
            foreach (ops[i]) begin
                issue("alu_ops", 5'd10, 5'd11, rnd(), k[0], ops[i], 5'd12,
                      1'b1, 1'b0, 1'b0, WB_ALU);
            end
        end

        // forwarding at distance one and two with ex/mem priority and register zero
        issue("forward", 5'd0, 5'd0, 32'h11, 1'b1, ALU_ADD, 5'd3, 1'b1, 1'b0, 1'b0, WB_ALU);
        issue("forward", 5'd0, 5'd0, 32'h22, 1'b1, ALU_ADD, 5'd3, 1'b1, 1'b0, 1'b0, WB_ALU);
        issue("forward", 5'd3, 5'd3, 32'h0, 1'b0, ALU_ADD, 5'd4, 1'b1, 1'b0, 1'b0, WB_ALU);
        issue("forward", 5'd0, 5'd0, 32'h77, 1'b1, ALU_OR, 5'd0, 1'b1, 1'b0, 1'b0, WB_ALU);
        issue("forward", 5'd0, 5'd4, 32'h0, 1'b0, ALU_ADD, 5'd5, 1'b1, 1'b0, 1'b0, WB_ALU);

        // fill every word with a pattern of the whole address
        for (int i = 0; i < (1 << `DMEM_ADDR_W); i++) begin
            issue("fill", 5'd0, 5'd0, {16'h0, i[7:0] ^ 8'h5a, 8'hc3}, 1'b1, ALU_LUI, 5'd6,
                  1'b1, 1'b0, 1'b0, WB_ALU);
            issue("fill", 5'd0, 5'd6, {22'h0, i[7:0], 2'b00}, 1'b1, ALU_ADD, 5'd0,
                  1'b0, 1'b1, 1'b0, WB_ALU);
        end

        // store then an unrelated op then a load back
        issue("store_load", 5'd0, 5'd12, 32'h40, 1'b1, ALU_ADD, 5'd0, 1'b0, 1'b1, 1'b0, WB_ALU);
        issue("store_load", 5'd1, 5'd2, 32'h0, 1'b0, ALU_XOR, 5'd7, 1'b1, 1'b0, 1'b0, WB_ALU);
        issue("store_load", 5'd0, 5'd0, 32'h40, 1'b1, ALU_ADD, 5'd8, 1'b1, 1'b0, 1'b1, WB_MEM);
        bubble("store_load");
        for (int i = 0; i < 8; i++) begin
            issue("load", 5'd0, 5'd0, {22'h0, i[7:0] * 8'd31, 2'b00}, 1'b1, ALU_ADD, 5'd9,
                  1'b1, 1'b0, 1'b1, WB_MEM);
        end

        // link value and suppressed writes
        issue("link", 5'd1, 5'd2, 32'h5, 1'b1, ALU_ADD, 5'd31, 1'b1, 1'b0, 1'b0, WB_LINK);
        bubble("link");
        issue("no_write", 5'd1, 5'd2, 32'h8, 1'b1, ALU_ADD, 5'd13, 1'b0, 1'b0, 1'b1, WB_MEM);
        issue("no_write", 5'd1, 5'd2, 32'h8, 1'b1, ALU_ADD, 5'd13, 1'b0, 1'b0, 1'b0, WB_LINK);

        // dense hazards on few registers before the full file
        repeat (400) random_instr("mix_narrow", 3);
        repeat (400) random_instr("mix_wide", 31);
        repeat (3) bubble("drain");

        guard = 0;
        while (q_tag.size() > 0 && guard < 50) begin
            @(negedge clk);
            guard++;
        end
        if (q_tag.size() > 0) begin
            $display("timeout: %0d expected writebacks never came out", q_tag.size());
            $display("=== FAIL ===");
            $finish;
        end else begin
            $display("errors: %0d", errors);
            if (errors == 0) begin
                $display("=== PASS ===");
            end else begin
                $display("=== FAIL ===");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+verilog
verilog/isa_pkg.sv
verilog/datapath_pkg.sv
verilog/alu.sv
verilog/execute_stage.sv
verilog/ex_mem.sv
verilog/data_memory.sv
verilog/writeback_stage.sv
verilog/pipeline_backend.sv
verif/tb_pipeline_backend.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the pipeline backend testbench
cd "$(dirname "$0")" &&
verilator --binary --timing -f compile.f --top-module tb_pipeline_backend -o sim &&
./obj_dir/sim | tee /dev/stderr | grep -q "=== PASS ===" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
